// ==== rtl/ice_basics_pkg.sv ====
`default_nettype none

package ice_basics_pkg;

	typedef logic [7:0] byte_t;

	// Bit 8 flags the last word of a frame
	typedef logic [8:0] rsp_word_t;

	// Command addresses
	localparam byte_t CMD_VERSION    = 8'h76;
	localparam byte_t CMD_QUERY_I2C  = 8'h49;
	localparam byte_t CMD_SET_I2C    = 8'h69;
	localparam byte_t CMD_QUERY_GPIO = 8'h47;
	localparam byte_t CMD_SET_GPIO   = 8'h67;
	localparam byte_t CMD_QUERY_SW   = 8'h53;
	localparam byte_t CMD_SET_SW     = 8'h73;

	// Payload selector bytes
	localparam byte_t SEL_SPEED = "c";
	localparam byte_t SEL_ADDR  = "a";
	localparam byte_t SEL_LEVEL = "l";
	localparam byte_t SEL_DIR   = "d";

	localparam byte_t ACK_CODE = 8'h06;
	localparam byte_t NAK_CODE = 8'h15;

	localparam byte_t VERSION_MAJOR = 8'h00;
	localparam byte_t VERSION_MINOR = 8'h04;

	localparam int GPIO_W = 24;

	localparam byte_t       I2C_SPEED_RST = 8'd99;
	localparam logic [15:0] I2C_ADDR_RST  = 16'hFFFF;
	localparam logic [2:0]  SW_RST        = 3'b111;

	localparam int FIFO_DEPTH_LOG2 = 5;

	typedef enum logic [2:0] {
		PSEL_NONE,
		PSEL_I2C_SPEED,
		PSEL_I2C_ADDR,
		PSEL_GPIO_LEVEL,
		PSEL_GPIO_DIR,
		PSEL_GPIO_READ,
		PSEL_SW
	} param_sel_t;

	// Number of payload bytes carried by each register
	function automatic logic [1:0] sel_bytes(param_sel_t s);
		case (s)
			PSEL_NONE: return 2'd0;
			PSEL_I2C_ADDR: return 2'd2;
			PSEL_GPIO_LEVEL, PSEL_GPIO_DIR, PSEL_GPIO_READ: return 2'd3;
			default: return 2'd1;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== rtl/frame_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_parser import ice_basics_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  byte_t ma_data,
	input  logic  ma_data_valid,
	input  logic  ma_frame_valid,
	output logic  cmd_valid,
	output byte_t cmd_addr,
	output byte_t eid,
	output logic  pay_valid,
	output byte_t pay_byte
);

	typedef enum logic [1:0] {P_IDLE, P_EID, P_LEN, P_PAY} phase_t;

	phase_t phase;
	logic   fv_q;
	logic   frame_start;

	// Address byte comes with the rising edge of the frame
	assign frame_start = ma_frame_valid && !fv_q && ma_data_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			fv_q <= 1'b0;
			phase <= P_IDLE;
			cmd_valid <= 1'b0;
			pay_valid <= 1'b0;
		end else begin
			fv_q <= ma_frame_valid;
			cmd_valid <= 1'b0;
			pay_valid <= 1'b0;
			if (!ma_frame_valid) begin
				phase <= P_IDLE;
			end else if (frame_start) begin
				phase <= P_EID;
			end else if (ma_data_valid) begin
				case (phase)
					P_EID: phase <= P_LEN;
					// Length byte is skipped and the command is announced here
					P_LEN: begin
						phase <= P_PAY;
						cmd_valid <= 1'b1;
					end
					P_PAY: pay_valid <= 1'b1;
					default: phase <= P_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_start)
			cmd_addr <= ma_data;
		if (ma_data_valid && phase == P_EID)
			eid <= ma_data;
		if (ma_data_valid)
			pay_byte <= ma_data;
	end

	// Bus bytes only come inside a frame
	a_byte_in_frame: assert property (@(posedge clk) disable iff (rst)
		ma_data_valid |-> ma_frame_valid);

endmodule

`default_nettype wire

// ==== rtl/basics_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module basics_sequencer import ice_basics_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       cmd_valid,
	input  byte_t      cmd_addr,
	input  byte_t      eid,
	input  logic       pay_valid,
	input  byte_t      pay_byte,
	input  logic       generate_nak,
	output logic       ack_req,
	output logic       ack_is_nak,
	input  logic       ack_done,
	output byte_t      ack_eid,
	output logic       seq_req,
	output rsp_word_t  seq_word,
	input  logic       seq_ack,
	output param_sel_t sel,
	output logic       sel_load,
	output logic       wr_en,
	output byte_t      wr_byte,
	input  byte_t      rd_byte,
	input  logic       rd_last,
	output logic       rd_shift
);

	typedef enum logic [3:0] {
		S_IDLE, S_VER, S_VCHK, S_QSEL, S_SSEL, S_WRITE,
		S_ACK, S_ACK_END, S_DATA, S_DATA_END
	} state_t;

	state_t      state;
	byte_t       cmd;
	logic [15:0] version_in;
	logic        ver_idx;
	logic [1:0]  wr_cnt;
	logic        send_data;
	logic        data_ver;
	logic        accept;
	logic        ver_bad;
	param_sel_t  dec_sel;

	function automatic param_sel_t decode_sel(byte_t c, byte_t s);
		case (c)
			CMD_QUERY_I2C, CMD_SET_I2C:
				return (s == SEL_SPEED) ? PSEL_I2C_SPEED :
					(s == SEL_ADDR) ? PSEL_I2C_ADDR : PSEL_NONE;
			// Query of level reports the pins, not the driven level
			CMD_QUERY_GPIO:
				return (s == SEL_LEVEL) ? PSEL_GPIO_READ :
					(s == SEL_DIR) ? PSEL_GPIO_DIR : PSEL_NONE;
			CMD_SET_GPIO:
				return (s == SEL_LEVEL) ? PSEL_GPIO_LEVEL :
					(s == SEL_DIR) ? PSEL_GPIO_DIR : PSEL_NONE;
			CMD_QUERY_SW, CMD_SET_SW: return PSEL_SW;
			default: return PSEL_NONE;
		endcase
	endfunction

	assign dec_sel = decode_sel(cmd, pay_byte);
	assign ver_bad = version_in != {VERSION_MAJOR, VERSION_MINOR};

	// A new frame also aborts a command still waiting for payload
	assign accept = cmd_valid &&
		(state inside {S_IDLE, S_VER, S_QSEL, S_SSEL, S_WRITE});

	assign ack_req  = state == S_ACK;
	assign seq_req  = state == S_DATA;
	assign wr_en    = state == S_WRITE && pay_valid;
	assign wr_byte  = pay_byte;
	assign seq_word = data_ver ? {ver_idx, ver_idx ? VERSION_MINOR : VERSION_MAJOR} :
		{rd_last, rd_byte};
	assign rd_shift = state == S_DATA_END && !seq_ack && !seq_word[8] && !data_ver;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			sel <= PSEL_NONE;
			sel_load <= 1'b0;
			ack_is_nak <= 1'b0;
			ver_idx <= 1'b0;
			wr_cnt <= 2'd0;
			send_data <= 1'b0;
			data_ver <= 1'b0;
		end else begin
			sel_load <= 1'b0;
			if (state == S_IDLE && generate_nak) begin
				ack_eid <= eid;
				ack_is_nak <= 1'b1;
				send_data <= 1'b0;
				state <= S_ACK;
			end else if (accept) begin
				cmd <= cmd_addr;
				ack_eid <= eid;
				ack_is_nak <= 1'b0;
				ver_idx <= 1'b0;
				case (cmd_addr)
					CMD_VERSION: state <= S_VER;
					CMD_QUERY_I2C, CMD_QUERY_GPIO, CMD_QUERY_SW: state <= S_QSEL;
					CMD_SET_I2C, CMD_SET_GPIO, CMD_SET_SW: state <= S_SSEL;
					default: state <= S_IDLE;
				endcase
			end else begin
				case (state)
					S_VER: if (pay_valid) begin
						version_in <= {version_in[7:0], pay_byte};
						ver_idx <= 1'b1;
						if (ver_idx) begin
							ver_idx <= 1'b0;
							state <= S_VCHK;
						end
					end
					S_VCHK: begin
						ack_is_nak <= ver_bad;
						send_data <= ver_bad;
						data_ver <= 1'b1;
						state <= S_ACK;
					end
					S_QSEL: if (pay_valid) begin
						sel <= dec_sel;
						sel_load <= dec_sel != PSEL_NONE;
						send_data <= 1'b1;
						data_ver <= 1'b0;
						state <= (dec_sel == PSEL_NONE) ? S_IDLE : S_ACK;
					end
					S_SSEL: if (pay_valid) begin
						sel <= dec_sel;
						wr_cnt <= sel_bytes(dec_sel);
						send_data <= 1'b0;
						state <= (dec_sel == PSEL_NONE) ? S_IDLE : S_WRITE;
					end
					S_WRITE: if (pay_valid) begin
						wr_cnt <= wr_cnt - 2'd1;
						if (wr_cnt == 2'd1)
							state <= S_ACK;
					end
					S_ACK: if (ack_done)
						state <= S_ACK_END;
					S_ACK_END: if (!ack_done)
						state <= send_data ? S_DATA : S_IDLE;
					S_DATA: if (seq_ack)
						state <= S_DATA_END;
					S_DATA_END: if (!seq_ack) begin
						if (seq_word[8]) begin
							state <= S_IDLE;
						end else begin
							ver_idx <= 1'b1;
							state <= S_DATA;
						end
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	a_word_held: assert property (@(posedge clk) disable iff (rst)
		seq_req && $past(seq_req) |-> $stable(seq_word));

endmodule

`default_nettype wire

// ==== rtl/param_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module param_regs import ice_basics_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  param_sel_t        sel,
	input  logic              sel_load,
	input  logic              wr_en,
	input  byte_t             wr_byte,
	input  logic              rd_shift,
	output byte_t             rd_byte,
	output logic              rd_last,
	input  logic [GPIO_W-1:0] gpio_read,
	output byte_t             i2c_speed,
	output logic [15:0]       i2c_addr,
	output logic [GPIO_W-1:0] gpio_level,
	output logic [GPIO_W-1:0] gpio_direction,
	output logic              sw_0p6,
	output logic              sw_1p2,
	output logic              sw_vbatt
);

	logic [GPIO_W-1:0] staging;
	logic [GPIO_W-1:0] sel_value;
	logic [1:0]        rd_cnt;

	// Selected value left aligned so the top byte goes out first
	always_comb begin
		case (sel)
			PSEL_I2C_SPEED: sel_value = {i2c_speed, 16'h0000};
			PSEL_I2C_ADDR: sel_value = {i2c_addr, 8'h00};
			PSEL_GPIO_LEVEL: sel_value = gpio_level;
			PSEL_GPIO_DIR: sel_value = gpio_direction;
			PSEL_GPIO_READ: sel_value = gpio_read;
			PSEL_SW: sel_value = {5'b00000, sw_vbatt, sw_1p2, sw_0p6, 16'h0000};
			default: sel_value = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			i2c_speed <= I2C_SPEED_RST;
			i2c_addr <= I2C_ADDR_RST;
			gpio_level <= '0;
			gpio_direction <= '0;
			{sw_vbatt, sw_1p2, sw_0p6} <= SW_RST;
		end else if (wr_en) begin
			// Multi-byte values arrive most significant byte first
			case (sel)
				PSEL_I2C_SPEED: i2c_speed <= wr_byte;
				PSEL_I2C_ADDR: i2c_addr <= {i2c_addr[7:0], wr_byte};
				PSEL_GPIO_LEVEL: gpio_level <= {gpio_level[GPIO_W-9:0], wr_byte};
				PSEL_GPIO_DIR: gpio_direction <= {gpio_direction[GPIO_W-9:0], wr_byte};
				PSEL_SW: {sw_vbatt, sw_1p2, sw_0p6} <= wr_byte[2:0];
				default: i2c_speed <= i2c_speed;
			endcase
		end
	end

	// Countdown of bytes still to be read out
	always_ff @(posedge clk) begin
		if (rst)
			rd_cnt <= 2'd0;
		else if (sel_load)
			rd_cnt <= sel_bytes(sel);
		else if (rd_shift && rd_cnt != 2'd0)
			rd_cnt <= rd_cnt - 2'd1;
	end

	always_ff @(posedge clk) begin
		if (sel_load)
			staging <= sel_value;
		else if (rd_shift)
			staging <= {staging[GPIO_W-9:0], 8'h00};
	end

	assign rd_byte = staging[GPIO_W-1 -: 8];
	assign rd_last = rd_cnt == 2'd1;

endmodule

`default_nettype wire

// ==== rtl/ack_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module ack_generator import ice_basics_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      ack_req,
	input  logic      ack_is_nak,
	input  byte_t     ack_eid,
	output logic      ack_done,
	output logic      ag_req,
	output rsp_word_t ag_word,
	input  logic      ag_ack
);

	typedef enum logic [2:0] {
		A_IDLE, A_CODE, A_CODE_END, A_EID, A_EID_END, A_DONE
	} state_t;

	state_t state;

	assign ag_req   = state == A_CODE || state == A_EID;
	assign ack_done = state == A_DONE;

	// Code word first, then the eid closes the frame
	assign ag_word = (state == A_EID) ? {1'b1, ack_eid} :
		{1'b0, ack_is_nak ? NAK_CODE : ACK_CODE};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= A_IDLE;
		end else begin
			case (state)
				A_IDLE: if (ack_req) state <= A_CODE;
				A_CODE: if (ag_ack) state <= A_CODE_END;
				A_CODE_END: if (!ag_ack) state <= A_EID;
				A_EID: if (ag_ack) state <= A_EID_END;
				A_EID_END: if (!ag_ack) state <= A_DONE;
				// Hold done until the sequencer lets go of its request
				A_DONE: if (!ack_req) state <= A_IDLE;
				default: state <= A_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/response_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module response_arbiter import ice_basics_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      ag_req,
	input  rsp_word_t ag_word,
	output logic      ag_ack,
	input  logic      seq_req,
	input  rsp_word_t seq_word,
	output logic      seq_ack,
	output logic      fifo_wr,
	output rsp_word_t fifo_word,
	input  logic      fifo_full
);

	typedef enum logic [1:0] {R_IDLE, R_WR, R_ACK} phase_t;

	phase_t phase;
	logic   cur_seq;
	logic   locked;
	logic   grant_ag;
	logic   grant_seq;
	logic   cur_req;

	// A locked owner keeps the port until its frame is closed
	assign grant_ag  = ag_req && (!locked || !cur_seq);
	assign grant_seq = seq_req && (!locked || cur_seq) && !grant_ag;
	assign cur_req   = cur_seq ? seq_req : ag_req;

	assign fifo_word = cur_seq ? seq_word : ag_word;
	assign fifo_wr   = phase == R_WR && !fifo_full;
	assign ag_ack    = phase == R_ACK && !cur_seq;
	assign seq_ack   = phase == R_ACK && cur_seq;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= R_IDLE;
			cur_seq <= 1'b0;
			locked <= 1'b0;
		end else begin
			case (phase)
				R_IDLE: if (grant_ag || grant_seq) begin
					cur_seq <= grant_seq;
					phase <= R_WR;
				end
				R_WR: if (fifo_wr) begin
					locked <= !fifo_word[8];
					phase <= R_ACK;
				end
				R_ACK: if (!cur_req) phase <= R_IDLE;
				default: phase <= R_IDLE;
			endcase
		end
	end

	// The granted peer holds its request until the word is written
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		phase == R_WR |-> cur_req);

endmodule

`default_nettype wire

// ==== rtl/response_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module response_fifo import ice_basics_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      fifo_wr,
	input  rsp_word_t fifo_word,
	output logic      fifo_full,
	output logic      rsp_req,
	output rsp_word_t rsp_word,
	input  logic      rsp_ack
);

	rsp_word_t mem [2**FIFO_DEPTH_LOG2];

	// One extra pointer bit tells full from empty
	logic [FIFO_DEPTH_LOG2:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2:0] rd_ptr;
	logic                     empty;
	logic                     ack_wait;

	assign empty = wr_ptr == rd_ptr;
	assign fifo_full = wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2] &&
		wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0];

	assign rsp_req  = !empty && !ack_wait;
	assign rsp_word = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

	always_ff @(posedge clk) begin
		if (fifo_wr)
			mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= fifo_word;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			ack_wait <= 1'b0;
		end else begin
			if (fifo_wr)
				wr_ptr <= wr_ptr + 1'b1;
			// Pop once, then wait for the consumer to drop its ack
			if (rsp_req && rsp_ack) begin
				rd_ptr <= rd_ptr + 1'b1;
				ack_wait <= 1'b1;
			end else if (!rsp_ack) begin
				ack_wait <= 1'b0;
			end
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) fifo_wr |-> !fifo_full);

endmodule

`default_nettype wire

// ==== rtl/ice_basics_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ice_basics_top import ice_basics_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  byte_t             ma_data,
	input  logic              ma_data_valid,
	input  logic              ma_frame_valid,
	input  logic              generate_nak,
	input  logic [GPIO_W-1:0] gpio_read,
	output logic              rsp_req,
	output rsp_word_t         rsp_word,
	input  logic              rsp_ack,
	output byte_t             i2c_speed,
	output logic [15:0]       i2c_addr,
	output logic [GPIO_W-1:0] gpio_level,
	output logic [GPIO_W-1:0] gpio_direction,
	output logic              sw_0p6,
	output logic              sw_1p2,
	output logic              sw_vbatt
);

	logic       cmd_valid, pay_valid;
	byte_t      cmd_addr, eid, pay_byte;
	logic       ack_req, ack_is_nak, ack_done;
	byte_t      ack_eid;
	logic       ag_req, ag_ack, seq_req, seq_ack;
	rsp_word_t  ag_word, seq_word, fifo_word;
	logic       fifo_wr, fifo_full;
	param_sel_t sel;
	logic       sel_load, wr_en, rd_last, rd_shift;
	byte_t      wr_byte, rd_byte;

	frame_parser u_parser (.clk, .rst, .ma_data, .ma_data_valid, .ma_frame_valid,
		.cmd_valid, .cmd_addr, .eid, .pay_valid, .pay_byte);

	basics_sequencer u_seq (.clk, .rst, .cmd_valid, .cmd_addr, .eid, .pay_valid,
		.pay_byte, .generate_nak, .ack_req, .ack_is_nak, .ack_done, .ack_eid,
		.seq_req, .seq_word, .seq_ack, .sel, .sel_load, .wr_en, .wr_byte,
		.rd_byte, .rd_last, .rd_shift);

	param_regs u_regs (.clk, .rst, .sel, .sel_load, .wr_en, .wr_byte, .rd_shift,
		.rd_byte, .rd_last, .gpio_read, .i2c_speed, .i2c_addr, .gpio_level,
		.gpio_direction, .sw_0p6, .sw_1p2, .sw_vbatt);

	ack_generator u_ackgen (.clk, .rst, .ack_req, .ack_is_nak, .ack_eid, .ack_done,
		.ag_req, .ag_word, .ag_ack);

	response_arbiter u_arb (.clk, .rst, .ag_req, .ag_word, .ag_ack, .seq_req,
		.seq_word, .seq_ack, .fifo_wr, .fifo_word, .fifo_full);

	response_fifo u_fifo (.clk, .rst, .fifo_wr, .fifo_word, .fifo_full, .rsp_req,
		.rsp_word, .rsp_ack);

endmodule

`default_nettype wire

// ==== testbench/tb_ice_basics.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ice_basics;

	localparam int N_CMDS = 20;
	// Frame, idle gap and up to five response words per command
	localparam int CMD_BOUND = 200;
	localparam int TIMEOUT_CYCLES = 16 + N_CMDS * CMD_BOUND;
	localparam int WORD_WAIT = 150;

	localparam logic [7:0] ADDR_VERSION    = 8'h76;
	localparam logic [7:0] ADDR_QUERY_I2C  = 8'h49;
	localparam logic [7:0] ADDR_SET_I2C    = 8'h69;
	localparam logic [7:0] ADDR_QUERY_GPIO = 8'h47;
	localparam logic [7:0] ADDR_SET_GPIO   = 8'h67;
	localparam logic [7:0] ADDR_QUERY_SW   = 8'h53;
	localparam logic [7:0] ADDR_SET_SW     = 8'h73;
	localparam logic [7:0] ADDR_UNKNOWN    = 8'h5a;
	localparam logic [7:0] PICK_SPEED = 8'h63;
	localparam logic [7:0] PICK_ADDR  = 8'h61;
	localparam logic [7:0] PICK_LEVEL = 8'h6c;
	localparam logic [7:0] PICK_DIR   = 8'h64;
	// Switch commands ignore their selector byte
	localparam logic [7:0] PICK_ANY   = 8'h73;
	localparam logic [7:0] CODE_ACK = 8'h06;
	localparam logic [7:0] CODE_NAK = 8'h15;

	logic        clk;
	logic        rst;
	logic [7:0]  ma_data;
	logic        ma_data_valid;
	logic        ma_frame_valid;
	logic        generate_nak;
	logic [23:0] gpio_read;
	logic        rsp_req;
	logic [8:0]  rsp_word;
	logic        rsp_ack;
	logic [7:0]  i2c_speed;
	logic [15:0] i2c_addr;
	logic [23:0] gpio_level;
	logic [23:0] gpio_direction;
	logic        sw_0p6;
	logic        sw_1p2;
	logic        sw_vbatt;

	logic [8:0]  rx_q[$];
	logic [31:0] lcg_state;
	int          cycles;
	int          mismatches;
	int          failures;

	ice_basics_top i_dut (
		.clk, .rst, .ma_data, .ma_data_valid, .ma_frame_valid, .generate_nak,
		.gpio_read, .rsp_req, .rsp_word, .rsp_ack, .i2c_speed, .i2c_addr,
		.gpio_level, .gpio_direction, .sw_0p6, .sw_1p2, .sw_vbatt
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = rand_word();
		return r[31:24];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			mismatches++;
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Pops the next collected word, waiting a bounded time for it
	task automatic check_word(input logic [8:0] exp);
		int         waited;
		logic [8:0] got;
		waited = 0;
		while (rx_q.size() == 0 && waited < WORD_WAIT) begin
			@(posedge clk);
			waited++;
		end
		assert (rx_q.size() != 0) else begin
			failures++;
			$display("No response word arrived within %0d cycles", WORD_WAIT);
		end
		if (rx_q.size() != 0) begin
			got = rx_q.pop_front();
			check_value("rsp_word", got, exp);
		end
	endtask

	task automatic expect_ack(input logic is_nak, input logic [7:0] fe);
		check_word({1'b0, is_nak ? CODE_NAK : CODE_ACK});
		check_word({1'b1, fe});
	endtask

	// Data frame goes most significant byte first with the last flag on the final byte
	task automatic expect_data(input int n, input logic [23:0] value);
		int i;
		for (i = 0; i < n; i++)
			check_word({i == n - 1, value[8 * (n - 1 - i) +: 8]});
	endtask

	task automatic send_frame(input logic [7:0] addr, input logic [7:0] fe,
			input int len, input logic [31:0] pay);
		int i;
		repeat (8) @(posedge clk);
		ma_frame_valid <= 1'b1;
		ma_data_valid <= 1'b1;
		ma_data <= addr;
		@(posedge clk);
		ma_data <= fe;
		@(posedge clk);
		ma_data <= len[7:0];
		for (i = 0; i < len; i++) begin
			@(posedge clk);
			ma_data <= pay[8 * (len - 1 - i) +: 8];
		end
		@(posedge clk);
		ma_frame_valid <= 1'b0;
		ma_data_valid <= 1'b0;
	endtask

	task automatic pulse_nak();
		repeat (8) @(posedge clk);
		generate_nak <= 1'b1;
		@(posedge clk);
		generate_nak <= 1'b0;
	endtask

	// Four-phase consumer of the response queue
	initial begin
		rsp_ack = 1'b0;
		forever begin
			@(posedge clk);
			if (!rst && rsp_req && !rsp_ack) begin
				rx_q.push_back(rsp_word);
				rsp_ack <= 1'b1;
				repeat (3) @(posedge clk);
				rsp_ack <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		logic [7:0]  e;
		logic [7:0]  spd;
		logic [7:0]  sw_val;
		logic [15:0] adr;
		logic [15:0] ver;
		logic [23:0] lvl;
		logic [23:0] dir;
		logic [23:0] pins;
		int          k;
		lcg_state = 32'h8c5a0c09;
		cycles = 0;
		mismatches = 0;
		failures = 0;
		rst = 1'b1;
		ma_data = 8'h00;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		generate_nak = 1'b0;
		gpio_read = 24'h000000;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// Reset values
		e = rand_byte();
		send_frame(ADDR_QUERY_I2C, e, 1, PICK_SPEED);
		expect_ack(1'b0, e);
		expect_data(1, 24'd99);
		e = rand_byte();
		send_frame(ADDR_QUERY_I2C, e, 1, PICK_ADDR);
		expect_ack(1'b0, e);
		expect_data(2, 24'h00ffff);
		e = rand_byte();
		send_frame(ADDR_QUERY_SW, e, 1, PICK_ANY);
		expect_ack(1'b0, e);
		expect_data(1, 24'h000007);

		// Version match, then mismatch
		e = rand_byte();
		send_frame(ADDR_VERSION, e, 2, 32'h0004);
		expect_ack(1'b0, e);
		ver = {rand_byte(), rand_byte()};
		if (ver == 16'h0004)
			ver = ver ^ 16'h0001;
		e = rand_byte();
		send_frame(ADDR_VERSION, e, 2, ver);
		expect_ack(1'b1, e);
		expect_data(2, 24'h000004);

		// I2C settings
		adr = {rand_byte(), rand_byte()};
		e = rand_byte();
		send_frame(ADDR_SET_I2C, e, 3, {PICK_ADDR, adr});
		expect_ack(1'b0, e);
		check_value("i2c_addr", i2c_addr, adr);
		spd = rand_byte();
		e = rand_byte();
		send_frame(ADDR_SET_I2C, e, 2, {PICK_SPEED, spd});
		expect_ack(1'b0, e);
		check_value("i2c_speed", i2c_speed, spd);
		e = rand_byte();
		send_frame(ADDR_QUERY_I2C, e, 1, PICK_ADDR);
		expect_ack(1'b0, e);
		expect_data(2, adr);
		e = rand_byte();
		send_frame(ADDR_QUERY_I2C, e, 1, PICK_SPEED);
		expect_ack(1'b0, e);
		expect_data(1, spd);

		// GPIO settings; a level query reports the pins
		lvl = {rand_byte(), rand_byte(), rand_byte()};
		e = rand_byte();
		send_frame(ADDR_SET_GPIO, e, 4, {PICK_LEVEL, lvl});
		expect_ack(1'b0, e);
		check_value("gpio_level", gpio_level, lvl);
		dir = {rand_byte(), rand_byte(), rand_byte()};
		e = rand_byte();
		send_frame(ADDR_SET_GPIO, e, 4, {PICK_DIR, dir});
		expect_ack(1'b0, e);
		check_value("gpio_direction", gpio_direction, dir);
		pins = {rand_byte(), rand_byte(), rand_byte()};
		@(posedge clk);
		gpio_read <= pins;
		e = rand_byte();
		send_frame(ADDR_QUERY_GPIO, e, 1, PICK_LEVEL);
		expect_ack(1'b0, e);
		expect_data(3, pins);
		e = rand_byte();
		send_frame(ADDR_QUERY_GPIO, e, 1, PICK_DIR);
		expect_ack(1'b0, e);
		expect_data(3, dir);

		// Power switches with vbatt on bit 2 down to 0p6 on bit 0
		for (k = 0; k < 2; k++) begin
			sw_val = rand_byte();
			e = rand_byte();
			send_frame(ADDR_SET_SW, e, 2, {PICK_ANY, sw_val});
			expect_ack(1'b0, e);
			check_value("sw_vbatt,sw_1p2,sw_0p6", {sw_vbatt, sw_1p2, sw_0p6}, sw_val[2:0]);
			e = rand_byte();
			send_frame(ADDR_QUERY_SW, e, 1, PICK_ANY);
			expect_ack(1'b0, e);
			expect_data(1, {21'd0, sw_val[2:0]});
		end

		// Unknown address stays silent and the NAK carries its eid
		e = rand_byte();
		send_frame(ADDR_UNKNOWN, e, 2, rand_word());
		repeat (40) @(posedge clk);
		assert (rx_q.size() == 0) else begin
			failures++;
			$display("Unknown address produced %0d response words", rx_q.size());
		end
		pulse_nak();
		expect_ack(1'b1, e);
		e = rand_byte();
		send_frame(ADDR_QUERY_I2C, e, 1, PICK_SPEED);
		expect_ack(1'b0, e);
		expect_data(1, spd);

		repeat (40) @(posedge clk);
		assert (rx_q.size() == 0) else begin
			failures++;
			$display("%0d unexpected response words left at the end", rx_q.size());
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ice_basics.f ====
rtl/ice_basics_pkg.sv
rtl/frame_parser.sv
rtl/basics_sequencer.sv
rtl/param_regs.sv
rtl/ack_generator.sv
rtl/response_arbiter.sv
rtl/response_fifo.sv
rtl/ice_basics_top.sv
testbench/tb_ice_basics.sv
